// File: rtl/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // 640x480 at 60 Hz horizontal timing in pixels
    localparam logic [9:0] h_active = 10'd640;
    localparam logic [9:0] h_fp     = 10'd16;
    localparam logic [9:0] h_sync   = 10'd96;
    localparam logic [9:0] h_bp     = 10'd48;

    // Vertical timing in lines
    localparam logic [9:0] v_active = 10'd480;
    localparam logic [9:0] v_fp     = 10'd11;
    localparam logic [9:0] v_sync   = 10'd2;
    localparam logic [9:0] v_bp     = 10'd32;

    localparam int text_cols   = 80;   // Cells across
    localparam int text_rows   = 30;   // Cells down, 8 lines each
    localparam int cell_addr_w = 12;
    localparam int cell_w      = 11;   // {r, g, b, code[7:0]}
    localparam int glyph_count = 12;
    localparam int pix_pipe    = 2;    // Counter position to RGB, in cycles

endpackage

`default_nettype wire

// File: rtl/raster_timing.sv
`timescale 1ns/1ns
`default_nettype none

module raster_timing #(
    parameter logic [9:0] h_active = vga_pkg::h_active,
    parameter logic [9:0] h_fp     = vga_pkg::h_fp,
    parameter logic [9:0] h_sync   = vga_pkg::h_sync,
    parameter logic [9:0] h_bp     = vga_pkg::h_bp,
    parameter logic [9:0] v_active = vga_pkg::v_active,
    parameter logic [9:0] v_fp     = vga_pkg::v_fp,
    parameter logic [9:0] v_sync   = vga_pkg::v_sync,
    parameter logic [9:0] v_bp     = vga_pkg::v_bp
) (
    input  logic       vgaclk,
    input  logic       rst,
    output logic [9:0] x,
    output logic [9:0] y,
    output logic       active,   // Undelayed, same cycle as x and y
    output logic       hsync,
    output logic       vsync,
    output logic       sync_b,
    output logic       blank_b
);
    import vga_pkg::*;

    localparam logic [9:0] h_total    = h_active + h_fp + h_sync + h_bp;   // 800
    localparam logic [9:0] v_total    = v_active + v_fp + v_sync + v_bp;   // 525
    localparam logic [9:0] h_sync_beg = h_active + h_fp;
    localparam logic [9:0] h_sync_end = h_sync_beg + h_sync;
    localparam logic [9:0] v_sync_beg = v_active + v_fp;
    localparam logic [9:0] v_sync_end = v_sync_beg + v_sync;

    logic [9:0] hcnt;
    logic [9:0] vcnt;
    logic       h_vis, v_vis;
    logic       hs_raw, vs_raw;

    // Shift registers, bit 0 is the newest stage
    logic [pix_pipe-1:0] hs_d, vs_d, sb_d, bl_d;

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == h_total - 10'd1) begin
            hcnt <= '0;   // End of line
            vcnt <= (vcnt == v_total - 10'd1) ? 10'd0 : vcnt + 10'd1;
        end else begin
            hcnt <= hcnt + 10'd1;
        end
    end

    assign h_vis  = (hcnt < h_active);
    assign v_vis  = (vcnt < v_active);
    assign active = h_vis & v_vis;

    // Positions read as 0 outside the visible span of each axis
    assign x = h_vis ? hcnt : 10'd0;
    assign y = v_vis ? vcnt : 10'd0;

    assign hs_raw = ~((hcnt >= h_sync_beg) && (hcnt < h_sync_end));   // Active low
    assign vs_raw = ~((vcnt >= v_sync_beg) && (vcnt < v_sync_end));

    // Align sync and blank with the pixel pipeline
    always_ff @(posedge vgaclk) begin
        if (rst) begin
            hs_d <= '1;
            vs_d <= '1;
            sb_d <= '1;
            bl_d <= '0;   // Blanked out of reset
        end else begin
            hs_d <= {hs_d[pix_pipe-2:0], hs_raw};
            vs_d <= {vs_d[pix_pipe-2:0], vs_raw};
            sb_d <= {sb_d[pix_pipe-2:0], hs_raw & vs_raw};
            bl_d <= {bl_d[pix_pipe-2:0], active};
        end
    end

    assign hsync   = hs_d[pix_pipe-1];
    assign vsync   = vs_d[pix_pipe-1];
    assign sync_b  = sb_d[pix_pipe-1];
    assign blank_b = bl_d[pix_pipe-1];

endmodule

`default_nettype wire

// File: rtl/text_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module text_buffer (
    input  logic                            vgaclk,
    input  logic                            wr_en,
    input  logic [vga_pkg::cell_addr_w-1:0] wr_addr,
    input  logic [vga_pkg::cell_w-1:0]      wr_data,
    input  logic [vga_pkg::cell_addr_w-1:0] rd_addr,
    output logic [vga_pkg::cell_w-1:0]      rd_data
);
    import vga_pkg::*;

    localparam int depth = text_cols * text_rows;   // 2400 cells

    logic [cell_w-1:0] mem [depth];

    // Host port, out of range writes are dropped
    always_ff @(posedge vgaclk) begin
        if (wr_en && (wr_addr < cell_addr_w'(depth))) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Display port with one cycle latency
    // Same cell read and written in one cycle gives the old word
    always_ff @(posedge vgaclk) begin
        if (rd_addr < cell_addr_w'(depth)) begin
            rd_data <= mem[rd_addr];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/glyph_rom.sv
`timescale 1ns/1ns
`default_nettype none

module glyph_rom (
    input  logic [7:0] code,
    input  logic [2:0] row,
    output logic [7:0] bits
);
    import vga_pkg::*;

    localparam int rom_rows = glyph_count * 8;

    logic [7:0] rom [rom_rows];   // Bit 7 is the leftmost pixel
    logic [6:0] idx;              // code*8 + row
    logic       known;

    initial begin
        $readmemb("rtl/glyph_rom.mem", rom);
    end

    assign known = (code < 8'(glyph_count));
    assign idx   = {code[3:0], row};

    // Codes past the stored set come out blank
    assign bits = known ? rom[idx] : 8'h00;

endmodule

`default_nettype wire

// File: rtl/text_pixel_gen.sv
`timescale 1ns/1ns
`default_nettype none

module text_pixel_gen (
    input  logic                            vgaclk,
    input  logic                            rst,
    input  logic [9:0]                      x,
    input  logic [9:0]                      y,
    input  logic                            active,
    output logic [vga_pkg::cell_addr_w-1:0] rd_addr,
    input  logic [vga_pkg::cell_w-1:0]      rd_data,
    output logic [7:0]                      r,
    output logic [7:0]                      g,
    output logic [7:0]                      b
);
    import vga_pkg::*;

    localparam int side_n = pix_pipe - 1;   // Matches buffer read latency

    logic [6:0]              col, row;
    logic [cell_addr_w-1:0]  cell_addr;
    logic                    in_text;
    logic [2:0]              xoff_q [side_n];
    logic [2:0]              yoff_q [side_n];
    logic [side_n-1:0]       act_q;
    logic [7:0]              glyph_bits;
    logic                    pix;

    assign col = x[9:3];
    assign row = y[9:3];

    // Text region covers the top 240 lines only
    assign in_text = active && (col < 7'(text_cols)) && (row < 7'(text_rows));

    assign cell_addr = cell_addr_w'(row) * cell_addr_w'(text_cols) + cell_addr_w'(col);
    assign rd_addr   = in_text ? cell_addr : '0;

    // Offsets ride alongside the buffer read
    always_ff @(posedge vgaclk) begin
        xoff_q[0] <= x[2:0];
        yoff_q[0] <= y[2:0];
        for (int i = 1; i < side_n; i++) begin
            xoff_q[i] <= xoff_q[i-1];
            yoff_q[i] <= yoff_q[i-1];
        end
    end

    always_ff @(posedge vgaclk) begin
        if (rst) act_q <= '0;
        else     act_q <= side_n'({act_q, in_text});
    end

    glyph_rom u_glyph_rom (
        .code (rd_data[7:0]),
        .row  (yoff_q[side_n-1]),
        .bits (glyph_bits)
    );

    assign pix = act_q[side_n-1] & glyph_bits[3'd7 - xoff_q[side_n-1]];

    // Colour bits 10..8 enable r, g, b
    always_ff @(posedge vgaclk) begin
        if (rst) begin
            r <= 8'h00;
            g <= 8'h00;
            b <= 8'h00;
        end else begin
            r <= {8{pix & rd_data[10]}};
            g <= {8{pix & rd_data[9]}};
            b <= {8{pix & rd_data[8]}};
        end
    end

endmodule

`default_nettype wire

// File: rtl/vga_text_top.sv
`timescale 1ns/1ns
`default_nettype none

module vga_text_top #(
    parameter logic [9:0] h_active = vga_pkg::h_active,
    parameter logic [9:0] h_fp     = vga_pkg::h_fp,
    parameter logic [9:0] h_sync   = vga_pkg::h_sync,
    parameter logic [9:0] h_bp     = vga_pkg::h_bp,
    parameter logic [9:0] v_active = vga_pkg::v_active,
    parameter logic [9:0] v_fp     = vga_pkg::v_fp,
    parameter logic [9:0] v_sync   = vga_pkg::v_sync,
    parameter logic [9:0] v_bp     = vga_pkg::v_bp
) (
    input  logic                            vgaclk,    // 25.175 MHz pixel clock
    input  logic                            rst,
    input  logic                            wr_en,     // Host write strobe
    input  logic [vga_pkg::cell_addr_w-1:0] wr_addr,   // row*80 + column
    input  logic [vga_pkg::cell_w-1:0]      wr_data,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            sync_b,
    output logic                            blank_b,
    output logic [7:0]                      r,
    output logic [7:0]                      g,
    output logic [7:0]                      b
);
    import vga_pkg::*;

    logic [9:0]             x, y;
    logic                   active;
    logic [cell_addr_w-1:0] rd_addr;
    logic [cell_w-1:0]      rd_data;

    raster_timing #(
        .h_active (h_active),
        .h_fp     (h_fp),
        .h_sync   (h_sync),
        .h_bp     (h_bp),
        .v_active (v_active),
        .v_fp     (v_fp),
        .v_sync   (v_sync),
        .v_bp     (v_bp)
    ) u_timing (
        .vgaclk  (vgaclk),
        .rst     (rst),
        .x       (x),
        .y       (y),
        .active  (active),
        .hsync   (hsync),
        .vsync   (vsync),
        .sync_b  (sync_b),
        .blank_b (blank_b)
    );

    text_buffer u_buffer (
        .vgaclk  (vgaclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    text_pixel_gen u_pixel (
        .vgaclk  (vgaclk),
        .rst     (rst),
        .x       (x),
        .y       (y),
        .active  (active),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .r       (r),
        .g       (g),
        .b       (b)
    );

endmodule

`default_nettype wire

// File: test/vga_text_checker.sv
`timescale 1ns/1ns
`default_nettype none

module vga_text_checker (
    input  logic       vgaclk,
    input  logic       rst,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       sync_b,
    input  logic       blank_b,
    input  logic [7:0] r,
    input  logic [7:0] g,
    input  logic [7:0] b,
    output int         frame,         // 1 until the first vsync fall
    output int         timing_errs,
    output int         pixel_errs
);
    localparam int max_checks = 64;

    // Pixel checks filled by the testbench at time 0
    int         c_frame [max_checks];
    int         c_x     [max_checks];
    int         c_y     [max_checks];
    logic [7:0] c_r     [max_checks];
    logic [7:0] c_g     [max_checks];
    logic [7:0] c_b     [max_checks];
    bit         c_hit   [max_checks];
    int         nc;

    logic hs_q, vs_q, bl_q;            // Previous samples for edge detection
    int   pix_cnt;                     // blank_b high cycles since vsync fell
    int   line_cyc, hs_low, bl_run, since_blank;
    int   lines, act_lines, vs_low;
    bit   line_act;                    // blank_b fell in this line
    int   px, py;

    task automatic check_timing(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, what, exp, act);
            timing_errs++;
        end
    endtask

    task automatic check_pixel(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s at x=%0d y=%0d expected %h, got %h",
                     $time, what, px, py, exp, act);
            pixel_errs++;
        end
    endtask

    // Samples before the edge updates so DUT flops give their settled values
    always @(posedge vgaclk) begin
        if (rst) begin
            frame       = 1;
            timing_errs = 0;
            pixel_errs  = 0;
            hs_q        = 1'b1;
            vs_q        = 1'b1;
            bl_q        = 1'b0;
        end else begin
            if (frame >= 2) check_timing("sync_b", int'(hsync & vsync), int'(sync_b));
            if (blank_b && !bl_q) bl_run = 0;                // Active run starts
            if (!blank_b && bl_q) begin
                if (frame >= 2) check_timing("blank_b high cycles", 640, bl_run);
                since_blank = 0;
                line_act    = 1'b1;
                act_lines++;
            end
            if (!hsync && hs_q) begin                        // One line per hsync fall
                if (frame >= 2) begin
                    check_timing("hsync period", 800, line_cyc);
                    if (line_act) check_timing("hsync fall after blank_b", 16, since_blank);
                end
                line_cyc = 0;
                hs_low   = 0;
                line_act = 1'b0;
                lines++;
            end
            if (hsync && !hs_q && frame >= 2) check_timing("hsync low cycles", 96, hs_low);
            if (vsync && !vs_q && frame >= 2) check_timing("vsync low cycles", 1600, vs_low);
            if (!vsync && vs_q) begin                        // Closes a frame
                if (frame >= 2) begin
                    check_timing("hsync pulses per vsync period", 525, lines);
                    check_timing("blank_b runs per vsync period", 480, act_lines);
                    check_timing("blank_b high cycles per vsync period", 640 * 480, pix_cnt);
                end
                frame++;
                pix_cnt   = 0;
                lines     = 0;
                act_lines = 0;
                vs_low    = 0;
            end
            if (blank_b) begin
                px = pix_cnt % 640;
                py = pix_cnt / 640;
                for (int k = 0; k < nc; k++) begin
                    if (c_frame[k] == frame && c_x[k] == px && c_y[k] == py) begin
                        check_pixel("r", c_r[k], r);
                        check_pixel("g", c_g[k], g);
                        check_pixel("b", c_b[k], b);
                        c_hit[k] = 1'b1;
                    end
                end
                pix_cnt++;
            end else if (frame >= 2 && (r | g | b) !== 8'h00) begin
                $display("** Error at %0t ns: rgb expected 000000 in blanking, got %h%h%h",
                         $time, r, g, b);
                pixel_errs++;
            end
            line_cyc++;
            since_blank++;
            if (blank_b) bl_run++;
            if (!hsync) hs_low++;
            if (!vsync) vs_low++;
            hs_q = hsync;
            vs_q = vsync;
            bl_q = blank_b;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_vga_text.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vga_text;
    localparam int frame_cycles = 800 * 525;
    localparam int timeout_ns   = 4 * frame_cycles * 4 + 200_000;   // Four frames plus margin
    localparam int max_writes   = 64;

    logic        vgaclk;
    logic        rst;
    logic        wr_en;
    logic [11:0] wr_addr;
    logic [10:0] wr_data;
    logic        hsync, vsync, sync_b, blank_b;
    logic [7:0]  r, g, b;

    int          w_frame [max_writes];   // Frame in which each write is applied
    logic [11:0] w_addr  [max_writes];
    logic [10:0] w_data  [max_writes];
    int          nw;
    int          other_errs;             // File and timeout failures
    int          frame, timing_errs, pixel_errs;

    vga_text_top vga_text_top_i (
        .vgaclk  (vgaclk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .hsync   (hsync),
        .vsync   (vsync),
        .sync_b  (sync_b),
        .blank_b (blank_b),
        .r       (r),
        .g       (g),
        .b       (b)
    );

    vga_text_checker checker_i (
        .vgaclk      (vgaclk),
        .rst         (rst),
        .hsync       (hsync),
        .vsync       (vsync),
        .sync_b      (sync_b),
        .blank_b     (blank_b),
        .r           (r),
        .g           (g),
        .b           (b),
        .frame       (frame),
        .timing_errs (timing_errs),
        .pixel_errs  (pixel_errs)
    );

    always #2 vgaclk = ~vgaclk;   // 4 ns period

    // W lines fill the write list and C lines the checker's arrays
    task automatic read_vector_file();
        int          fd, code, fr, x, y, nc;
        logic [11:0] a;
        logic [10:0] d;
        logic [7:0]  er, eg, eb;
        string       line;
        nc = 0;
        fd = $fopen("test/vga_text_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/vga_text_testdata.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                break;
            end
            if ($sscanf(line, "W %d %h %h", fr, a, d) == 3 && nw < max_writes) begin
                w_frame[nw] = fr;
                w_addr[nw]  = a;
                w_data[nw]  = d;
                nw++;
            end else if ($sscanf(line, "C %d %d %d %h %h %h", fr, x, y, er, eg, eb) == 6
                         && nc < max_writes) begin
                checker_i.c_frame[nc] = fr;
                checker_i.c_x[nc]     = x;
                checker_i.c_y[nc]     = y;
                checker_i.c_r[nc]     = er;
                checker_i.c_g[nc]     = eg;
                checker_i.c_b[nc]     = eb;
                nc++;
            end
        end
        $fclose(fd);
        checker_i.nc = nc;
    endtask

    // One write strobe per cycle with no back-pressure
    task automatic write_frame(input int fr);
        for (int i = 0; i < nw; i++) begin
            if (w_frame[i] == fr) begin
                @(posedge vgaclk);
                wr_en   <= 1'b1;
                wr_addr <= w_addr[i];
                wr_data <= w_data[i];
            end
        end
        @(posedge vgaclk);
        wr_en <= 1'b0;
    endtask

    task automatic end_run();
        int missed;
        int total;
        missed = 0;
        for (int k = 0; k < checker_i.nc; k++) begin
            if (!checker_i.c_hit[k]) begin
                $display("Pixel check at x=%0d y=%0d in frame %0d was never reached",
                         checker_i.c_x[k], checker_i.c_y[k], checker_i.c_frame[k]);
                missed++;
            end
        end
        total = timing_errs + pixel_errs + missed + other_errs;
        $display("Errors: timing %0d, pixel %0d, missed %0d, other %0d",
                 timing_errs, pixel_errs, missed, other_errs);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        vgaclk     = 1'b0;
        rst        = 1'b1;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        nw         = 0;
        other_errs = 0;
        read_vector_file();
        repeat (10) @(posedge vgaclk);
        rst <= 1'b0;
        write_frame(1);       // Cells filled while the first frame scans
        wait (frame >= 3);    // vsync fall after frame 2 while still in vertical blanking
        write_frame(2);
        wait (frame >= 4);    // Frame 3 fully checked
        repeat (4) @(posedge vgaclk);
        end_run();
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the display never finished its third frame", timeout_ns);
        other_errs++;
        end_run();
    end

endmodule

`default_nettype wire

// File: rtl/glyph_rom.mem
00111100
01000010
01000110
01011010
01100010
01000010
00111100
00000000
00011000
00111000
00011000
00011000
00011000
00011000
01111110
00000000
00111100
01000010
00000010
00001100
00110000
01000000
01111110
00000000
00111100
01000010
00000010
00011100
00000010
01000010
00111100
00000000
00000100
00001100
00010100
00100100
01111110
00000100
00000100
00000000
01111110
01000000
01111100
00000010
00000010
01000010
00111100
00000000
00111100
01000000
01111100
01000010
01000010
01000010
00111100
00000000
01111110
00000010
00000100
00001000
00010000
00010000
00010000
00000000
00111100
01000010
01000010
00111100
01000010
01000010
00111100
00000000
00111100
01000010
01000010
00111110
00000010
00000100
00111000
00000000
11111111
11111111
11111111
11111111
11111111
11111111
11111111
11111111
10101010
01010101
10101010
01010101
10101010
01010101
10101010
01010101

// File: test/vga_text_testdata.txt
# W frame addr word (hex): word is {r,g,b,code}, frame 1 after reset, frame 2 in its vblank
# C frame x y r g b: expected channels in hex at pixel (x, y) of that frame
W 1 000 70A
W 1 04F 40B
W 1 910 201
W 1 95F 108
W 1 4D8 60A
W 1 4D9 30A
W 1 4DA 50A
W 1 4DB 00A
W 1 4DC 704
W 1 4DD 70C
W 1 4DE 7FF
W 1 4DF 000
W 1 4B0 70A
W 2 4B0 700
C 2 0 0 ff ff ff
C 2 632 0 ff 00 00
C 2 633 0 00 00 00
C 2 633 1 ff 00 00
C 2 3 232 00 ff 00
C 2 2 233 00 ff 00
C 2 634 235 00 00 ff
C 2 633 233 00 00 ff
C 2 320 120 ff ff 00
C 2 328 121 00 ff ff
C 2 336 122 ff 00 ff
C 2 344 123 00 00 00
C 2 353 124 ff ff ff
C 2 357 120 ff ff ff
C 2 360 120 00 00 00
C 2 368 121 00 00 00
C 2 376 122 00 00 00
C 2 100 300 00 00 00
C 2 0 120 ff ff ff
C 3 0 120 00 00 00
C 3 2 120 ff ff ff

// File: build.f
rtl/vga_pkg.sv
rtl/raster_timing.sv
rtl/text_buffer.sv
rtl/glyph_rom.sv
rtl/text_pixel_gen.sv
rtl/vga_text_top.sv
test/vga_text_checker.sv
test/tb_vga_text.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the VGA text display testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_vga_text \
    -Mdir obj_dir -o sim_vga_text
./obj_dir/sim_vga_text | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
